/* spi_config.svh */
//**************************************************************************
// SPI peripheral port configuration
// Sizes and constants shared by every block of the SPI peripheral port
//**************************************************************************

`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// Width of every byte path between the peripheral and the sub-peripherals
`define SPI_BYTE_WIDTH 8

// Number of byte registers in the scratch sub-peripheral
`define SPI_SCRATCH_COUNT 8

// CRC-8 polynomial, x^8 + x^2 + x + 1, with an initial value of zero
`define SPI_CRC_POLY 8'h07

// Flops between each SPI pin and the clock domain
`define SPI_SYNC_STAGES 2

`endif

/* spi_pkg.sv */
//**************************************************************************
// SPI peripheral port types
// States, sub-peripheral addresses and scratch commands
//**************************************************************************

`include "spi_config.svh"

package spi_pkg;

    // Receiver progress through one chip-select window
    typedef enum logic [1:0] {
        IDLE,
        ADDRESS,
        DATA
    } spi_rx_state_t;

    // First byte of a transaction picks the sub-peripheral
    typedef enum logic [`SPI_BYTE_WIDTH-1:0] {
        SUBPERIPHERAL_SCRATCH  = 8'hA0,
        SUBPERIPHERAL_CHECKSUM = 8'hB5
    } subperipheral_addr_t;

    // Bit 7 of the scratch command byte
    typedef enum logic {
        SCRATCH_READ  = 1'b0,
        SCRATCH_WRITE = 1'b1
    } scratch_command_t;

endpackage

/* spi_peripheral.sv */
//**************************************************************************
// SPI peripheral
// Mode-0 byte receiver and transmitter, oversampled by the system clock.
// Splits each transaction into an address byte and data byte strobes.
//**************************************************************************

`timescale 1ns/1ps
`include "spi_config.svh"

module spi_peripheral
    import spi_pkg::*;
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       sck,
    input  logic                       cs_n,
    input  logic                       copi,
    output logic                       cipo,
    output logic [`SPI_BYTE_WIDTH-1:0] address,
    output logic                       address_valid,
    output logic [`SPI_BYTE_WIDTH-1:0] peripheral_data_in,
    output logic                       peripheral_data_in_valid,
    input  logic [`SPI_BYTE_WIDTH-1:0] peripheral_data_out,
    input  logic                       peripheral_data_out_valid
);
    localparam int COUNT_WIDTH = $clog2(`SPI_BYTE_WIDTH);
    localparam int SYNC_MSB = `SPI_SYNC_STAGES - 1;

    logic [SYNC_MSB:0]            sck_sync;
    logic [SYNC_MSB:0]            cs_n_sync;
    logic [SYNC_MSB:0]            copi_sync;
    logic                         sck_last;
    logic                         sck_rise;
    logic                         sck_fall;
    spi_rx_state_t                state;
    logic [COUNT_WIDTH-1:0]       bit_count;
    logic [`SPI_BYTE_WIDTH-1:0]   rx_shift;
    logic [`SPI_BYTE_WIDTH-1:0]   rx_byte;
    logic [`SPI_BYTE_WIDTH-1:0]   tx_shift;
    logic [`SPI_BYTE_WIDTH-1:0]   reply;

    // Chip select idles high, so its synchronizer resets to ones
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            sck_sync  <= '0;
            cs_n_sync <= '1;
            copi_sync <= '0;
            sck_last  <= 1'b0;
        end else begin
            sck_sync  <= {sck_sync[SYNC_MSB-1:0], sck};
            cs_n_sync <= {cs_n_sync[SYNC_MSB-1:0], cs_n};
            copi_sync <= {copi_sync[SYNC_MSB-1:0], copi};
            sck_last  <= sck_sync[SYNC_MSB];
        end
    end

    assign sck_rise = sck_sync[SYNC_MSB] & ~sck_last;
    assign sck_fall = ~sck_sync[SYNC_MSB] & sck_last;
    assign rx_byte  = {rx_shift[`SPI_BYTE_WIDTH-2:0], copi_sync[SYNC_MSB]};

    // Receive side. The eighth rising edge completes a byte
    always_ff @(posedge clock) begin
        peripheral_data_in_valid <= 1'b0;
        if (!rst_n || cs_n_sync[SYNC_MSB]) begin
            state         <= IDLE;
            bit_count     <= '0;
            rx_shift      <= '0;
            address       <= '0;
            address_valid <= 1'b0;
        end else begin
            if (state == IDLE) begin
                state <= ADDRESS;
            end
            if (sck_rise) begin
                rx_shift  <= rx_byte;
                bit_count <= bit_count + 1'b1;
                if (bit_count == COUNT_WIDTH'(`SPI_BYTE_WIDTH - 1)) begin
                    if (state == DATA) begin
                        peripheral_data_in       <= rx_byte;
                        peripheral_data_in_valid <= 1'b1;
                    end else begin
                        address       <= rx_byte;
                        address_valid <= 1'b1;
                        state         <= DATA;
                    end
                end
            end
        end
    end

    // Transmit side. The falling edge that ends a byte loads the latched reply,
    // which is then zero if the selected block never answered
    always_ff @(posedge clock) begin
        if (!rst_n || cs_n_sync[SYNC_MSB]) begin
            reply    <= '0;
            tx_shift <= '0;
        end else if (sck_fall && bit_count == '0) begin
            tx_shift <= reply;
            reply    <= '0;
        end else begin
            if (sck_fall) begin
                tx_shift <= {tx_shift[`SPI_BYTE_WIDTH-2:0], 1'b0};
            end
            if (peripheral_data_out_valid) begin
                reply <= peripheral_data_out;
            end
        end
    end

    assign cipo = tx_shift[`SPI_BYTE_WIDTH-1];

endmodule

/* spi_subperipheral_selector.sv */
//**************************************************************************
// SPI sub-peripheral selector
// Steers data strobes to the addressed sub-peripheral and returns its reply
//**************************************************************************

`timescale 1ns/1ps
`include "spi_config.svh"

module spi_subperipheral_selector
    import spi_pkg::*;
(
    input  logic [`SPI_BYTE_WIDTH-1:0] address,
    input  logic                       address_valid,
    input  logic [`SPI_BYTE_WIDTH-1:0] peripheral_data_in,
    input  logic                       peripheral_data_in_valid,
    output logic [`SPI_BYTE_WIDTH-1:0] peripheral_data_out,
    output logic                       peripheral_data_out_valid,

    output logic                       subperipheral_1_enable,
    output logic [`SPI_BYTE_WIDTH-1:0] subperipheral_1_data_out,
    output logic                       subperipheral_1_data_out_valid,
    input  logic [`SPI_BYTE_WIDTH-1:0] subperipheral_1_data_in,
    input  logic                       subperipheral_1_data_in_valid,

    output logic                       subperipheral_2_enable,
    output logic [`SPI_BYTE_WIDTH-1:0] subperipheral_2_data_out,
    output logic                       subperipheral_2_data_out_valid,
    input  logic [`SPI_BYTE_WIDTH-1:0] subperipheral_2_data_in,
    input  logic                       subperipheral_2_data_in_valid
);

    always_comb begin
        // Nothing selected unless a known address is held
        peripheral_data_out            = '0;
        peripheral_data_out_valid      = 1'b0;
        subperipheral_1_enable         = 1'b0;
        subperipheral_1_data_out       = '0;
        subperipheral_1_data_out_valid = 1'b0;
        subperipheral_2_enable         = 1'b0;
        subperipheral_2_data_out       = '0;
        subperipheral_2_data_out_valid = 1'b0;

        if (address_valid) begin
            case (address)
                SUBPERIPHERAL_SCRATCH: begin
                    peripheral_data_out            = subperipheral_1_data_in;
                    peripheral_data_out_valid      = subperipheral_1_data_in_valid;
                    subperipheral_1_enable         = 1'b1;
                    subperipheral_1_data_out       = peripheral_data_in;
                    subperipheral_1_data_out_valid = peripheral_data_in_valid;
                end
                SUBPERIPHERAL_CHECKSUM: begin
                    peripheral_data_out            = subperipheral_2_data_in;
                    peripheral_data_out_valid      = subperipheral_2_data_in_valid;
                    subperipheral_2_enable         = 1'b1;
                    subperipheral_2_data_out       = peripheral_data_in;
                    subperipheral_2_data_out_valid = peripheral_data_in_valid;
                end
                default: begin
                    // Unknown address, the controller reads zeros
                    peripheral_data_out       = '0;
                    peripheral_data_out_valid = 1'b0;
                end
            endcase
        end
    end

endmodule

/* spi_scratch_registers.sv */
//**************************************************************************
// SPI scratch registers
// Eight byte registers with auto-incrementing read and write access
//**************************************************************************

`timescale 1ns/1ps
`include "spi_config.svh"

module spi_scratch_registers
    import spi_pkg::*;
(
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic [`SPI_BYTE_WIDTH-1:0] data_in,
    input  logic                       data_in_valid,
    output logic [`SPI_BYTE_WIDTH-1:0] data_out,
    output logic                       data_out_valid
);
    localparam int INDEX_WIDTH = $clog2(`SPI_SCRATCH_COUNT);

    logic [`SPI_BYTE_WIDTH-1:0] registers [`SPI_SCRATCH_COUNT];
    logic [INDEX_WIDTH-1:0]     index;
    logic [INDEX_WIDTH-1:0]     start_index;
    logic                       expect_command;
    scratch_command_t           mode;
    scratch_command_t           command;

    assign command     = scratch_command_t'(data_in[`SPI_BYTE_WIDTH-1]);
    assign start_index = data_in[INDEX_WIDTH-1:0];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < `SPI_SCRATCH_COUNT; i++) begin
                registers[i] <= '0;
            end
            index          <= '0;
            expect_command <= 1'b1;
            mode           <= SCRATCH_READ;
            data_out_valid <= 1'b0;
        end else begin
            data_out_valid <= enable && data_in_valid;
            if (!enable) begin
                expect_command <= 1'b1;
            end else if (data_in_valid) begin
                if (expect_command) begin
                    expect_command <= 1'b0;
                    mode           <= command;
                    // A read answers the command byte itself, a write does not
                    if (command == SCRATCH_READ) begin
                        data_out <= registers[start_index];
                        index    <= start_index + 1'b1;
                    end else begin
                        data_out <= '0;
                        index    <= start_index;
                    end
                end else begin
                    data_out <= registers[index];
                    index    <= index + 1'b1;
                    if (mode == SCRATCH_WRITE) begin
                        registers[index] <= data_in;
                    end
                end
            end
        end
    end

endmodule

/* spi_checksum_unit.sv */
//**************************************************************************
// SPI checksum unit
// Running CRC-8 over the data bytes of the current transaction
//**************************************************************************

`timescale 1ns/1ps
`include "spi_config.svh"

module spi_checksum_unit (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enable,
    input  logic [`SPI_BYTE_WIDTH-1:0] data_in,
    input  logic                       data_in_valid,
    output logic [`SPI_BYTE_WIDTH-1:0] data_out,
    output logic                       data_out_valid
);
    logic [`SPI_BYTE_WIDTH-1:0] crc;
    logic [`SPI_BYTE_WIDTH-1:0] crc_next;

    // Bitwise CRC-8, MSB first, no reflection and no final XOR
    function automatic logic [`SPI_BYTE_WIDTH-1:0] crc8_update(
        input logic [`SPI_BYTE_WIDTH-1:0] current,
        input logic [`SPI_BYTE_WIDTH-1:0] data
    );
        logic [`SPI_BYTE_WIDTH-1:0] value;
        value = current ^ data;
        for (int i = 0; i < `SPI_BYTE_WIDTH; i++) begin
            if (value[`SPI_BYTE_WIDTH-1]) begin
                value = (value << 1) ^ `SPI_CRC_POLY;
            end else begin
                value = value << 1;
            end
        end
        return value;
    endfunction

    assign crc_next = crc8_update(crc, data_in);

    always_ff @(posedge clock) begin
        if (!rst_n || !enable) begin
            crc            <= '0;
            data_out_valid <= 1'b0;
        end else begin
            data_out_valid <= data_in_valid;
            if (data_in_valid) begin
                crc      <= crc_next;
                data_out <= crc_next;
            end
        end
    end

endmodule

/* spi_top.sv */
//**************************************************************************
// SPI peripheral port top level
// Peripheral, selector, scratch registers and checksum unit
//**************************************************************************

`timescale 1ns/1ps
`include "spi_config.svh"

module spi_top (
    input  logic clock,
    input  logic rst_n,
    input  logic sck,
    input  logic cs_n,
    input  logic copi,
    output logic cipo
);
    logic [`SPI_BYTE_WIDTH-1:0] address;
    logic                       address_valid;
    logic [`SPI_BYTE_WIDTH-1:0] peripheral_data_in;
    logic                       peripheral_data_in_valid;
    logic [`SPI_BYTE_WIDTH-1:0] peripheral_data_out;
    logic                       peripheral_data_out_valid;

    // Sub-peripheral 1 is the scratch block, 2 is the checksum
    logic                       sub_1_enable;
    logic [`SPI_BYTE_WIDTH-1:0] sub_1_to_block;
    logic                       sub_1_to_block_valid;
    logic [`SPI_BYTE_WIDTH-1:0] sub_1_reply;
    logic                       sub_1_reply_valid;
    logic                       sub_2_enable;
    logic [`SPI_BYTE_WIDTH-1:0] sub_2_to_block;
    logic                       sub_2_to_block_valid;
    logic [`SPI_BYTE_WIDTH-1:0] sub_2_reply;
    logic                       sub_2_reply_valid;

    spi_peripheral i_peripheral (
        .clock                     (clock),
        .rst_n                     (rst_n),
        .sck                       (sck),
        .cs_n                      (cs_n),
        .copi                      (copi),
        .cipo                      (cipo),
        .address                   (address),
        .address_valid             (address_valid),
        .peripheral_data_in        (peripheral_data_in),
        .peripheral_data_in_valid  (peripheral_data_in_valid),
        .peripheral_data_out       (peripheral_data_out),
        .peripheral_data_out_valid (peripheral_data_out_valid)
    );

    spi_subperipheral_selector i_selector (
        .address                        (address),
        .address_valid                  (address_valid),
        .peripheral_data_in             (peripheral_data_in),
        .peripheral_data_in_valid       (peripheral_data_in_valid),
        .peripheral_data_out            (peripheral_data_out),
        .peripheral_data_out_valid      (peripheral_data_out_valid),
        .subperipheral_1_enable         (sub_1_enable),
        .subperipheral_1_data_out       (sub_1_to_block),
        .subperipheral_1_data_out_valid (sub_1_to_block_valid),
        .subperipheral_1_data_in        (sub_1_reply),
        .subperipheral_1_data_in_valid  (sub_1_reply_valid),
        .subperipheral_2_enable         (sub_2_enable),
        .subperipheral_2_data_out       (sub_2_to_block),
        .subperipheral_2_data_out_valid (sub_2_to_block_valid),
        .subperipheral_2_data_in        (sub_2_reply),
        .subperipheral_2_data_in_valid  (sub_2_reply_valid)
    );

    spi_scratch_registers i_scratch (
        .clock          (clock),
        .rst_n          (rst_n),
        .enable         (sub_1_enable),
        .data_in        (sub_1_to_block),
        .data_in_valid  (sub_1_to_block_valid),
        .data_out       (sub_1_reply),
        .data_out_valid (sub_1_reply_valid)
    );

    spi_checksum_unit i_checksum (
        .clock          (clock),
        .rst_n          (rst_n),
        .enable         (sub_2_enable),
        .data_in        (sub_2_to_block),
        .data_in_valid  (sub_2_to_block_valid),
        .data_out       (sub_2_reply),
        .data_out_valid (sub_2_reply_valid)
    );

endmodule

/* spi_tb.sv */
//**************************************************************************
// SPI peripheral port testbench
// Bit-bangs mode-0 SPI transactions read from the test data file and
// compares every byte shifted out on cipo with the expected reply
//**************************************************************************

`timescale 1ns/1ps
`include "spi_config.svh"

module spi_tb
    import spi_pkg::*;
();
    localparam int MEM_DEPTH       = 512;
    localparam int CYCLES_PER_BYTE = 64;
    localparam int PHASE_CYCLES    = 4;

    logic clock = 1'b0;
    logic rst_n;
    logic sck;
    logic cs_n;
    logic copi;
    logic cipo;

    // Records of count, MOSI bytes, expected MISO bytes, closed by a zero count
    logic [`SPI_BYTE_WIDTH-1:0] test_bytes [MEM_DEPTH];

    int error_count     = 0;
    int check_count     = 0;
    int watchdog_cycles = 0;

    spi_top i_dut (
        .clock (clock),
        .rst_n (rst_n),
        .sck   (sck),
        .cs_n  (cs_n),
        .copi  (copi),
        .cipo  (cipo)
    );

    always #50 clock = ~clock;

    // Walks the records and adds up their byte counts
    function automatic int total_test_bytes();
        int base;
        int count;
        int total;
        base  = 0;
        total = 0;
        while (base < MEM_DEPTH) begin
            count = int'(test_bytes[base]);
            if (count == 0) begin
                break;
            end
            total += count;
            base  += 1 + 2 * count;
        end
        return total;
    endfunction

    function automatic string target_name(input logic [7:0] address, input logic [7:0] command);
        scratch_command_t mode;
        mode = scratch_command_t'(command[7]);
        case (address)
            SUBPERIPHERAL_SCRATCH: begin
                if (mode == SCRATCH_WRITE) begin
                    return "scratch write";
                end
                return "scratch read";
            end
            SUBPERIPHERAL_CHECKSUM: return "checksum";
            default: return "unselected address";
        endcase
    endfunction

    // One byte, MSB first. cipo is taken at the end of the low phase,
    // which is the value the controller sees at the rising sck edge
    task automatic transfer_byte(input logic [7:0] mosi, output logic [7:0] miso);
        for (int i = 7; i >= 0; i--) begin
            @(posedge clock);
            sck  <= 1'b0;
            copi <= mosi[i];
            repeat (PHASE_CYCLES - 1) @(posedge clock);
            @(negedge clock);
            miso[i] = cipo;
            @(posedge clock);
            sck <= 1'b1;
            repeat (PHASE_CYCLES - 1) @(posedge clock);
        end
    endtask

    task automatic run_transaction(input int base, input int count, input int number);
        logic [7:0] cipo_byte;
        logic [7:0] expected;
        int         idle_cycles;
        $display("Transaction %0d: %0d bytes, %s", number, count,
                 target_name(test_bytes[base + 1], test_bytes[base + 2]));
        @(posedge clock);
        cs_n <= 1'b0;
        repeat (PHASE_CYCLES) @(posedge clock);
        for (int k = 0; k < count; k++) begin
            transfer_byte(test_bytes[base + 1 + k], cipo_byte);
            expected = test_bytes[base + 1 + count + k];
            check_count++;
            if (cipo_byte !== expected) begin
                $display("ERROR: cipo_byte = 0x%02h, expected 0x%02h (transaction %0d, byte %0d)",
                         cipo_byte, expected, number, k);
                error_count++;
            end
        end
        @(posedge clock);
        sck  <= 1'b0;
        copi <= 1'b0;
        repeat (PHASE_CYCLES) @(posedge clock);
        cs_n <= 1'b1;
        idle_cycles = PHASE_CYCLES + ($urandom % 4);
        repeat (idle_cycles) @(posedge clock);
    endtask

    initial begin
        int base;
        int count;
        int record_count;
        rst_n <= 1'b0;
        sck   <= 1'b0;
        cs_n  <= 1'b1;
        copi  <= 1'b0;
        void'($urandom(48789));
        $readmemh("spi_testdata.txt", test_bytes);
        watchdog_cycles = total_test_bytes() * CYCLES_PER_BYTE + 1000;

        repeat (16) @(posedge clock);
        rst_n <= 1'b1;
        repeat (PHASE_CYCLES) @(posedge clock);

        base         = 0;
        record_count = 0;
        while (base < MEM_DEPTH) begin
            count = int'(test_bytes[base]);
            if (count == 0) begin
                break;
            end
            if (base + 2 * count >= MEM_DEPTH) begin
                $display("Test data record at offset %0d runs past the end of the array", base);
                error_count++;
                break;
            end
            record_count++;
            run_transaction(base, count, record_count);
            base += 1 + 2 * count;
        end
        if (record_count == 0) begin
            $display("No transactions were found in the test data file");
            error_count++;
        end

        $display("Checked %0d bytes in %0d transactions, %0d errors",
                 check_count, record_count, error_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from the number of bytes in the test data
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("Timeout: the test did not finish within %0d clock cycles", watchdog_cycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* spi_testdata.txt */
// Each record: byte count, then the MOSI bytes, then the expected MISO bytes, in hex
// A count of 00 ends the list
// Scratch writes from index 3, the second returns the first one's data
06 A0 83 11 22 33 44 00 00 00 00 00 00
05 A0 83 55 66 77 00 00 00 11 22
// Scratch read from index 3
06 A0 03 00 00 00 00 00 00 55 66 77 44
// Ten writes from index 6 wrap to index 0, then all eight are read back
0C A0 86 01 02 03 04 05 06 07 08 09 0A 00 00 00 44 00 00 00 00 55 66 77 01
0A A0 00 FF FF FF FF FF FF FF FF 00 00 03 04 05 06 07 08 09 0A
// Checksum, the second transaction starts again from zero
06 B5 01 02 03 04 00 00 00 07 1B 48 E3
04 B5 01 FF 00 00 00 07 E6
// Unselected address reads zeros and leaves the scratch registers alone
06 42 83 DE AD BE EF 00 00 00 00 00 00
06 A0 03 FF FF FF FF 00 00 06 07 08 09
00

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f all.f --top-module spi_tb -o spi_sim
output=$(./obj_dir/spi_sim)
echo "$output"
echo "$output" | grep -qx "TESTBENCH PASSED"

/* all.f */
+incdir+.
spi_pkg.sv
spi_peripheral.sv
spi_subperipheral_selector.sv
spi_scratch_registers.sv
spi_checksum_unit.sv
spi_top.sv
spi_tb.sv
